/* ycbcr2rgb_converter.f */
verilog/ycbcr_pkg.sv
verilog/block_buffer_ram.sv
verilog/block_writer.sv
verilog/block_reader.sv
verilog/ycbcr_to_rgb565.sv
verilog/ycbcr2rgb_converter.sv
tests/tb_ycbcr2rgb_converter.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -j 0 \
   --top-module tb_ycbcr2rgb_converter -f ycbcr2rgb_converter.f -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^all tests passed$" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

/* tests/tb_ycbcr2rgb_converter.sv */
`timescale 1ns/1ns

module tb_ycbcr2rgb_converter;

   localparam int NPIX        = ycbcr_pkg::LUMA_PER_BLOCK;
   localparam int NCHROMA     = ycbcr_pkg::CHROMA_PER_BLOCK;
   localparam int BLOCK_BYTES = NPIX + 2 * NCHROMA;

   logic               clock;
   logic               reset_n;
   logic               sample_valid;
   ycbcr_pkg::sample_t sample_data;
   logic               rgb_valid;
   ycbcr_pkg::rgb565_t rgb_data;

   // Current block in arrival order: Y, then Cb, then Cr
   ycbcr_pkg::sample_t blk [BLOCK_BYTES];
   ycbcr_pkg::sample_t saved_blk [BLOCK_BYTES];

   ycbcr_pkg::rgb565_t exp_q [$];
   ycbcr_pkg::rgb565_t got_q [$];
   int                 pix_count;
   int                 base;
   int                 value_errs;
   int                 timeout_errs;
   int                 other_errs;

   ycbcr2rgb_converter u_dut (
      .clock        (clock),
      .reset_n      (reset_n),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .rgb_valid    (rgb_valid),
      .rgb_data     (rgb_data)
   );

   // 40 ns period
   always #20 clock = ~clock;

   // ======================================================================
   // Reference model
   // ======================================================================

   function automatic int clamp_byte(input int v);
      if (v < 0)
         return 0;
      else if (v > 255)
         return 255;
      else
         return v;
   endfunction

   // Fixed-point BT.601, then 5-6-5 from the top bits
   function automatic ycbcr_pkg::rgb565_t rgb_of(input ycbcr_pkg::sample_t y,
                                                 input ycbcr_pkg::sample_t cb,
                                                 input ycbcr_pkg::sample_t cr);
      int cbo;
      int cro;
      int r;
      int g;
      int b;
      cbo = int'(cb) - 128;
      cro = int'(cr) - 128;
      r   = clamp_byte(int'(y) + ((359 * cro) >>> 8));
      g   = clamp_byte(int'(y) - ((88 * cbo + 183 * cro) >>> 8));
      b   = clamp_byte(int'(y) + ((454 * cbo) >>> 8));
      return {r[7:3], g[7:2], b[7:3]};
   endfunction

   // Expected pixels of blk, chroma placed by half-row
   task automatic queue_expected();
      ycbcr_pkg::sample_t cb_st [NCHROMA];
      ycbcr_pkg::sample_t cr_st [NCHROMA];
      int r;
      int c;
      int idx;
      for (int k = 0; k < NCHROMA; k++)
      begin
         r   = k / ycbcr_pkg::CHROMA_ROW;
         c   = k % ycbcr_pkg::CHROMA_ROW;
         // Left half of a row to the upper half-block
         idx = (c < 4) ? 4 * r + c : NCHROMA / 2 + 4 * r + (c - 4);
         cb_st[idx] = blk[NPIX + k];
         cr_st[idx] = blk[NPIX + NCHROMA + k];
      end
      for (int n = 0; n < NPIX; n++)
         exp_q.push_back(rgb_of(blk[n], cb_st[n / 2], cr_st[n / 2]));
   endtask

   // ======================================================================
   // Checks and waits
   // ======================================================================

   task automatic check_pixel(input string what, input ycbcr_pkg::rgb565_t got,
                              input ycbcr_pkg::rgb565_t exp);
      if (got !== exp)
      begin
         value_errs++;
         $display("Fail at %0t ns: %s got %04h expected %04h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp)
      begin
         value_errs++;
         $display("Fail at %0t ns: %s count %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic wait_pixels(input int target, input int limit);
      int cycles;
      cycles = 0;
      while (pix_count < target && cycles < limit)
      begin
         @(posedge clock);
         cycles++;
      end
      if (pix_count < target)
      begin
         timeout_errs++;
         $display("Timeout: only %0d of %0d pixels arrived within %0d cycles",
                  pix_count, target, limit);
      end
   endtask

   task automatic fill_random();
      for (int i = 0; i < BLOCK_BYTES; i++)
         blk[i] = ycbcr_pkg::sample_t'($urandom());
   endtask

   // One strobe per byte, optional idle cycles after each
   task automatic send_block(input int max_gap);
      int gap;
      for (int i = 0; i < BLOCK_BYTES; i++)
      begin
         @(negedge clock);
         sample_valid = 1'b1;
         sample_data  = blk[i];
         gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
         for (int g = 0; g < gap; g++)
         begin
            @(negedge clock);
            sample_valid = 1'b0;
         end
      end
      @(negedge clock);
      sample_valid = 1'b0;
   endtask

   // One full block, counted and compared
   task automatic run_block(input string what, input int max_gap);
      base = pix_count;
      got_q.delete();
      queue_expected();
      send_block(max_gap);
      wait_pixels(base + NPIX, 4 * BLOCK_BYTES + 2000);
      repeat (30) @(posedge clock);
      check_count(what, pix_count - base, NPIX);
   endtask

   // Pixel monitor, outputs are settled at the falling edge
   always @(negedge clock)
   begin
      if (reset_n && rgb_valid)
      begin
         pix_count++;
         got_q.push_back(rgb_data);
         if (exp_q.size() == 0)
         begin
            other_errs++;
            $display("Unexpected pixel at %0t ns with nothing left to compare", $time);
         end
         else
            check_pixel("pixel", rgb_data, exp_q.pop_front());
      end
   end

   // ======================================================================
   // Stimulus
   // ======================================================================

   initial
   begin
      void'($urandom(32'ha1d0_4c5d));
      clock        = 1'b0;
      reset_n      = 1'b0;
      sample_valid = 1'b0;
      sample_data  = '0;
      pix_count    = 0;
      value_errs   = 0;
      timeout_errs = 0;
      other_errs   = 0;
      repeat (8) @(posedge clock);
      @(negedge clock);
      reset_n = 1'b1;

      // Quiet output with no input
      repeat (60) @(posedge clock);
      check_count("pixels before input", pix_count, 0);

      // Random block, back to back
      fill_random();
      saved_blk = blk;
      run_block("random block pixels", 0);

      // Saturation, upper half bright red, lower half black with Cb at 0
      for (int n = 0; n < NPIX; n++)
         blk[n] = (n < NPIX / 2) ? 8'd255 : 8'd0;
      for (int k = 0; k < NCHROMA; k++)
      begin
         blk[NPIX + k]           = 8'd0;
         blk[NPIX + NCHROMA + k] = 8'd255;
      end
      run_block("clamp block pixels", 0);
      if (got_q.size() == NPIX)
      begin
         check_pixel("red saturation", got_q[0] & 16'hf800, 16'hf800);
         check_pixel("blue clamp", got_q[NPIX / 2] & 16'h001f, 16'h0000);
      end

      // Same data as the first block, with gaps
      blk = saved_blk;
      run_block("gapped block pixels", 3);

      // Four blocks, next one written while the last is read
      base = pix_count;
      for (int b = 0; b < 4; b++)
      begin
         fill_random();
         queue_expected();
         send_block(0);
         repeat (200) @(negedge clock);
      end
      wait_pixels(base + 4 * NPIX, 4000);
      repeat (30) @(posedge clock);
      check_count("four-block pixels", pix_count - base, 4 * NPIX);
      check_count("pending expected pixels", exp_q.size(), 0);

      $display("Errors: %0d value, %0d timeout, %0d unexpected",
               value_errs, timeout_errs, other_errs);
      if (value_errs + timeout_errs + other_errs == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* verilog/ycbcr2rgb_converter.sv */
`timescale 1ns/1ns

module ycbcr2rgb_converter #(
   parameter int LUMA_PER_BLOCK = ycbcr_pkg::LUMA_PER_BLOCK
) (
   input  logic               clock,
   input  logic               reset_n,
   input  logic               sample_valid,
   input  ycbcr_pkg::sample_t sample_data,
   output logic               rgb_valid,
   output ycbcr_pkg::rgb565_t rgb_data
);

   // Writer side
   logic                   wr_en;
   ycbcr_pkg::buf_addr_t   wr_addr;
   ycbcr_pkg::sample_t     wr_data;
   logic                   block_ready;

   // Reader side
   logic                   rd_en;
   ycbcr_pkg::buf_addr_t   rd_addr;
   ycbcr_pkg::sample_t     rd_data;
   ycbcr_pkg::read_phase_t rd_phase;

   // Sorts bytes into the write bank
   block_writer #(
      .LUMA_PER_BLOCK (LUMA_PER_BLOCK)
   ) u_writer (
      .clock        (clock),
      .reset_n      (reset_n),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .block_ready  (block_ready)
   );

   // Ping-pong buffer
   block_buffer_ram u_ram (
      .clock   (clock),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // Three reads per pixel from the finished bank
   block_reader #(
      .LUMA_PER_BLOCK (LUMA_PER_BLOCK)
   ) u_reader (
      .clock       (clock),
      .reset_n     (reset_n),
      .block_ready (block_ready),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .rd_phase    (rd_phase)
   );

   // Colour conversion and output register
   ycbcr_to_rgb565 u_colour (
      .clock     (clock),
      .reset_n   (reset_n),
      .rd_phase  (rd_phase),
      .rd_data   (rd_data),
      .rgb_valid (rgb_valid),
      .rgb_data  (rgb_data)
   );

endmodule

/* verilog/ycbcr_to_rgb565.sv */
`timescale 1ns/1ns

module ycbcr_to_rgb565 (
   input  logic                   clock,
   input  logic                   reset_n,
   input  ycbcr_pkg::read_phase_t rd_phase,
   input  ycbcr_pkg::sample_t     rd_data,
   output logic                   rgb_valid,
   output ycbcr_pkg::rgb565_t     rgb_data
);

   // BT.601 coefficients scaled by 256
   localparam logic signed [17:0] K_CR_R = 18'sd359;
   localparam logic signed [17:0] K_CB_G = 18'sd88;
   localparam logic signed [17:0] K_CR_G = 18'sd183;
   localparam logic signed [17:0] K_CB_B = 18'sd454;

   // Components held until Cr shows up
   ycbcr_pkg::sample_t y_hold;
   ycbcr_pkg::sample_t cb_hold;

   logic signed [8:0]  cb_c;
   logic signed [8:0]  cr_c;

   // Stage 1
   logic               s1_valid;
   ycbcr_pkg::sample_t s1_y;
   logic signed [17:0] s1_r;
   logic signed [17:0] s1_g;
   logic signed [17:0] s1_b;

   // Stage 2 sums before clamping
   logic signed [17:0] r_full;
   logic signed [17:0] g_full;
   logic signed [17:0] b_full;
   ycbcr_pkg::sample_t r8;
   ycbcr_pkg::sample_t g8;
   ycbcr_pkg::sample_t b8;

   // Saturate to one byte
   function automatic ycbcr_pkg::sample_t clamp8(input logic signed [17:0] v);
      if (v < 18'sd0)
         return 8'd0;
      else if (v > 18'sd255)
         return 8'd255;
      else
         return v[7:0];
   endfunction

   // ======================================================================
   // Gather and multiply
   // ======================================================================

   // Chroma offsets in -128..127
   assign cb_c = $signed({1'b0, cb_hold}) - 9'sd128;
   assign cr_c = $signed({1'b0, rd_data}) - 9'sd128;

   always_ff @(posedge clock)
   begin
      if (rd_phase == ycbcr_pkg::PH_Y)
         y_hold <= rd_data;
      if (rd_phase == ycbcr_pkg::PH_CB)
         cb_hold <= rd_data;
      // Cr is on rd_data right now
      if (rd_phase == ycbcr_pkg::PH_CR)
      begin
         s1_y <= y_hold;
         s1_r <= K_CR_R * cr_c;
         s1_g <= K_CB_G * cb_c + K_CR_G * cr_c;
         s1_b <= K_CB_B * cb_c;
      end
   end

   // ======================================================================
   // Add, clamp and pack
   // ======================================================================

   always_comb
   begin
      r_full = $signed({10'd0, s1_y}) + (s1_r >>> 8);
      g_full = $signed({10'd0, s1_y}) - (s1_g >>> 8);
      b_full = $signed({10'd0, s1_y}) + (s1_b >>> 8);
      r8     = clamp8(r_full);
      g8     = clamp8(g_full);
      b8     = clamp8(b_full);
   end

   always_ff @(posedge clock or negedge reset_n)
   begin
      if (!reset_n)
      begin
         s1_valid  <= 1'b0;
         rgb_valid <= 1'b0;
      end
      else
      begin
         s1_valid  <= (rd_phase == ycbcr_pkg::PH_CR);
         rgb_valid <= s1_valid;
      end
   end

   // 5-6-5 from the top bits
   always_ff @(posedge clock)
   begin
      if (s1_valid)
         rgb_data <= {r8[7:3], g8[7:2], b8[7:3]};
   end

   // Held Y and Cb must come from the two tags just before each Cr
   a_tag_order : assert property (@(posedge clock) disable iff (!reset_n)
      (rd_phase == ycbcr_pkg::PH_CR) |->
      ($past(rd_phase) == ycbcr_pkg::PH_CB) && ($past(rd_phase, 2) == ycbcr_pkg::PH_Y));

endmodule

/* verilog/block_reader.sv */
`timescale 1ns/1ns

module block_reader #(
   parameter int LUMA_PER_BLOCK = 128
) (
   input  logic                   clock,
   input  logic                   reset_n,
   input  logic                   block_ready,
   output logic                   rd_en,
   output ycbcr_pkg::buf_addr_t   rd_addr,
   output ycbcr_pkg::read_phase_t rd_phase
);

   ycbcr_pkg::read_phase_t phase;
   ycbcr_pkg::pixel_idx_t  pix;
   // Starts opposite to the writer once the first block is done
   logic                   bank;
   logic [8:0]             offset;

   // ======================================================================
   // Phase sequencer
   // ======================================================================

   always_ff @(posedge clock or negedge reset_n)
   begin
      if (!reset_n)
      begin
         phase    <= ycbcr_pkg::PH_IDLE;
         pix      <= '0;
         bank     <= 1'b0;
         rd_phase <= ycbcr_pkg::PH_IDLE;
      end
      else
      begin
         // Tag that lines up with the RAM output
         rd_phase <= phase;
         case (phase)
            ycbcr_pkg::PH_IDLE:
            begin
               if (block_ready)
                  phase <= ycbcr_pkg::PH_Y;
            end
            ycbcr_pkg::PH_Y:
               phase <= ycbcr_pkg::PH_CB;
            ycbcr_pkg::PH_CB:
               phase <= ycbcr_pkg::PH_CR;
            ycbcr_pkg::PH_CR:
            begin
               if (pix == 7'(LUMA_PER_BLOCK - 1))
               begin
                  // Block done so the next one comes from the other bank
                  phase <= ycbcr_pkg::PH_IDLE;
                  pix   <= '0;
                  bank  <= ~bank;
               end
               else
               begin
                  phase <= ycbcr_pkg::PH_Y;
                  pix   <= pix + 7'd1;
               end
            end
            default:
               phase <= ycbcr_pkg::PH_IDLE;
         endcase
      end
   end

   // Read address from phase and pixel
   // Pixel pairs share one chroma sample
   always_comb
   begin
      case (phase)
         ycbcr_pkg::PH_CB: offset = 9'(ycbcr_pkg::CB_BASE) + 9'(pix[6:1]);
         ycbcr_pkg::PH_CR: offset = 9'(ycbcr_pkg::CR_BASE) + 9'(pix[6:1]);
         default:          offset = 9'(pix);
      endcase
   end

   assign rd_en   = (phase != ycbcr_pkg::PH_IDLE);
   assign rd_addr = {bank, offset};

   // Source must leave room for a full read-out
   a_no_overrun : assert property (@(posedge clock) disable iff (!reset_n)
      block_ready |-> phase == ycbcr_pkg::PH_IDLE);

endmodule

/* verilog/block_writer.sv */
`timescale 1ns/1ns

module block_writer #(
   parameter int LUMA_PER_BLOCK = 128
) (
   input  logic                 clock,
   input  logic                 reset_n,
   input  logic                 sample_valid,
   input  ycbcr_pkg::sample_t   sample_data,
   output logic                 wr_en,
   output ycbcr_pkg::buf_addr_t wr_addr,
   output ycbcr_pkg::sample_t   wr_data,
   output logic                 block_ready
);

   localparam int CHROMA_N = LUMA_PER_BLOCK / 2;
   // Offset of the lower half-block inside a chroma region
   localparam int HALF_OFS = CHROMA_N / 2;
   localparam int HALF_ROW = ycbcr_pkg::CHROMA_ROW / 2;

   // Sample counts per component
   logic [7:0]      y_cnt;
   logic [6:0]      cb_cnt;
   logic [6:0]      cr_cnt;
   // Position inside the current chroma row
   logic [2:0]      row_pos;
   // Half-row counts, index 0 is Cb and 1 is Cr
   logic [1:0][5:0] lo_cnt;
   logic [1:0][5:0] hi_cnt;

   logic       bank;
   logic       last_write;

   logic       is_y;
   logic       sel_cr;
   logic       first_half;
   logic       last_cr;
   logic [8:0] chroma_base;
   logic [8:0] offset;

   // ======================================================================
   // Placement of the incoming byte
   // ======================================================================

   always_comb
   begin
      is_y        = (y_cnt < LUMA_PER_BLOCK);
      // Cr once all Cb bytes are in
      sel_cr      = (cb_cnt == 7'(CHROMA_N));
      first_half  = (row_pos < 3'(HALF_ROW));
      chroma_base = sel_cr ? 9'(ycbcr_pkg::CR_BASE) : 9'(ycbcr_pkg::CB_BASE);
      if (is_y)
         offset = 9'(y_cnt);
      else if (first_half)
         offset = chroma_base + 9'(lo_cnt[sel_cr]);
      else
         offset = chroma_base + 9'(HALF_OFS) + 9'(hi_cnt[sel_cr]);
      // Final byte of the block
      last_cr = sample_valid && !is_y && sel_cr && (cr_cnt == 7'(CHROMA_N - 1));
   end

   // ======================================================================
   // Counters, bank and block end
   // ======================================================================

   always_ff @(posedge clock or negedge reset_n)
   begin
      if (!reset_n)
      begin
         y_cnt       <= '0;
         cb_cnt      <= '0;
         cr_cnt      <= '0;
         row_pos     <= '0;
         lo_cnt      <= '0;
         hi_cnt      <= '0;
         bank        <= 1'b0;
         last_write  <= 1'b0;
         block_ready <= 1'b0;
         wr_en       <= 1'b0;
      end
      else
      begin
         wr_en       <= sample_valid;
         last_write  <= last_cr;
         // Pulse once the last Cr byte has gone into the RAM
         block_ready <= last_write;
         if (last_write)
            bank <= ~bank;

         if (sample_valid)
         begin
            if (is_y)
               y_cnt <= y_cnt + 8'd1;
            else
            begin
               row_pos <= (row_pos == 3'(ycbcr_pkg::CHROMA_ROW - 1)) ? 3'd0 : row_pos + 3'd1;
               if (first_half)
                  lo_cnt[sel_cr] <= lo_cnt[sel_cr] + 6'd1;
               else
                  hi_cnt[sel_cr] <= hi_cnt[sel_cr] + 6'd1;
               if (sel_cr)
                  cr_cnt <= cr_cnt + 7'd1;
               else
                  cb_cnt <= cb_cnt + 7'd1;
            end
         end

         // Ready for the next block
         if (last_cr)
         begin
            y_cnt   <= '0;
            cb_cnt  <= '0;
            cr_cnt  <= '0;
            row_pos <= '0;
            lo_cnt  <= '0;
            hi_cnt  <= '0;
         end
      end
   end

   // Write address and data
   always_ff @(posedge clock)
   begin
      wr_addr <= {bank, offset};
      wr_data <= sample_data;
   end

   // Nothing lands beyond the Cr region
   a_wr_in_bank : assert property (@(posedge clock) disable iff (!reset_n)
      wr_en |-> wr_addr[8:0] < 9'(ycbcr_pkg::CR_BASE + CHROMA_N));

endmodule

/* verilog/block_buffer_ram.sv */
`timescale 1ns/1ns

module block_buffer_ram (
   input  logic                 clock,
   input  logic                 wr_en,
   input  ycbcr_pkg::buf_addr_t wr_addr,
   input  ycbcr_pkg::sample_t   wr_data,
   input  logic                 rd_en,
   input  ycbcr_pkg::buf_addr_t rd_addr,
   output ycbcr_pkg::sample_t   rd_data
);

   // Both banks in one array, bank picked by the top address bit
   localparam int DEPTH = 2 ** $bits(ycbcr_pkg::buf_addr_t);

   ycbcr_pkg::sample_t mem [DEPTH];

   // Write port
   always_ff @(posedge clock)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read port, one cycle latency
   // Output holds its value while rd_en is low
   always_ff @(posedge clock)
   begin
      if (rd_en)
      begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

/* verilog/ycbcr_pkg.sv */
package ycbcr_pkg;

   // ======================================================================
   // Block geometry
   // ======================================================================

   // One Y sample per pixel
   localparam int LUMA_PER_BLOCK   = 128;
   // Each chroma plane holds one sample per pixel pair
   localparam int CHROMA_PER_BLOCK = LUMA_PER_BLOCK / 2;
   // Chroma arrives in rows; first half of a row belongs to the upper half-block
   localparam int CHROMA_ROW       = 8;

   // Region offsets inside one bank
   localparam int CB_BASE = 128;
   localparam int CR_BASE = 256;

   // ======================================================================
   // Types
   // ======================================================================

   // One Y, Cb or Cr byte
   typedef logic [7:0]  sample_t;
   // Packed 5-6-5 output pixel
   typedef logic [15:0] rgb565_t;
   // Bit 9 is the bank, bits 8:0 the offset in the bank
   typedef logic [9:0]  buf_addr_t;
   // Pixel number inside a block
   typedef logic [6:0]  pixel_idx_t;

   // Read sequencer phase, also tags the returning RAM data
   typedef enum logic [1:0] {
      PH_IDLE,
      PH_Y,
      PH_CB,
      PH_CR
   } read_phase_t;

endpackage
